/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

  // ------------------------------------------------------------
  // horizontal timing, 800x600 @ 60 Hz, 40 MHz pixel clock
  // ------------------------------------------------------------
  localparam int h_total    = 1056;  // clocks per line
  localparam int h_sync_len = 128;   // sync pulse
  localparam int h_de_start = 216;   // sync + back porch
  localparam int h_de_end   = 1016;  // + 800 active pixels

  // ------------------------------------------------------------
  // vertical timing, in lines
  // ------------------------------------------------------------
  localparam int v_total    = 628;
  localparam int v_sync_len = 4;
  localparam int v_de_start = 27;    // sync + back porch
  localparam int v_de_end   = 627;   // + 600 active lines

  // ------------------------------------------------------------
  // glyph geometry and placement
  // ------------------------------------------------------------
  localparam int glyph_w             = 56;
  localparam int glyph_h             = 75;
  localparam int glyph_bytes_per_row = 7;     // 56 / 8
  localparam int glyph_bytes         = 525;   // 7 * 75
  localparam int rom_depth           = 1050;  // two glyphs back to back
  localparam int rom_lead            = 2;     // addr -> data latency

  localparam int glyph0_x = 500;  // hcnt of leftmost column
  localparam int glyph0_y = 300;  // vcnt of top row
  localparam int glyph1_x = 650;
  localparam int glyph1_y = 300;

  // counter and address widths
  localparam int hcnt_w     = 11;
  localparam int vcnt_w     = 10;
  localparam int rom_addr_w = 11;

  // raster position plus the registered sync / enable flags
  typedef struct packed {
    logic [hcnt_w-1:0] hcnt;  // 1 .. h_total
    logic [vcnt_w-1:0] vcnt;  // 1 .. v_total
    logic              hsync; // active low
    logic              vsync; // active low
    logic              hde;   // horizontal display enable
    logic              vde;   // vertical display enable
  } raster_t;

  // 16-bit pixel, red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

endpackage

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
  input  logic             vga_clk,
  input  logic             reset_n,
  output vga_pkg::raster_t raster
);
  import vga_pkg::*;

  logic [hcnt_w-1:0] hcnt;
  logic [vcnt_w-1:0] vcnt;
  logic              hsync;
  logic              vsync;
  logic              hde;
  logic              vde;

  // ------------------------------------------------------------
  // line and frame counters start at 1
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (!reset_n) begin
      hcnt <= hcnt_w'(1);
    end else if (hcnt == hcnt_w'(h_total)) begin
      hcnt <= hcnt_w'(1);  // end of line
    end else begin
      hcnt <= hcnt + hcnt_w'(1);
    end
  end

  always_ff @(posedge vga_clk) begin
    if (!reset_n) begin
      vcnt <= vcnt_w'(1);
    end else if (hcnt == hcnt_w'(h_total)) begin  // step once per line
      if (vcnt == vcnt_w'(v_total))
        vcnt <= vcnt_w'(1);
      else
        vcnt <= vcnt + vcnt_w'(1);
    end
  end

  // ------------------------------------------------------------
  // sync and enable flops set and cleared on counter values
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (!reset_n) begin
      hsync <= 1'b1;
      hde   <= 1'b0;
    end else begin
      if (hcnt == hcnt_w'(1))
        hsync <= 1'b0;                          // low from H = 2
      else if (hcnt == hcnt_w'(h_sync_len))
        hsync <= 1'b1;                          // high again at H = 129
      if (hcnt == hcnt_w'(h_de_start))
        hde <= 1'b1;                            // first active pixel H = 217
      else if (hcnt == hcnt_w'(h_de_end))
        hde <= 1'b0;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (!reset_n) begin
      vsync <= 1'b1;
      vde   <= 1'b0;
    end else begin
      if (vcnt == vcnt_w'(1))
        vsync <= 1'b0;  // one clock after vcnt hits 1
      else if (vcnt == vcnt_w'(v_sync_len))
        vsync <= 1'b1;
      if (vcnt == vcnt_w'(v_de_start))
        vde <= 1'b1;
      else if (vcnt == vcnt_w'(v_de_end))
        vde <= 1'b0;
    end
  end

  assign raster = '{hcnt: hcnt, vcnt: vcnt, hsync: hsync, vsync: vsync,
                    hde: hde, vde: vde};

  // line counter never runs past the end of the line
  a_hcnt_max : assert property (@(posedge vga_clk) disable iff (!reset_n)
    hcnt <= hcnt_w'(h_total));

endmodule

`default_nettype wire

/* src/glyph_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_fetch (
  input  logic                           vga_clk,
  input  logic                           reset_n,
  input  vga_pkg::raster_t               raster,
  output logic [vga_pkg::rom_addr_w-1:0] rom_addr,
  output logic                           glyph_on
);
  import vga_pkg::*;

  logic [1:0]                 win;    // pixel window, per glyph
  logic [1:0]                 pre;    // early window, rom_lead clocks sooner
  logic [1:0]                 rows;   // vcnt inside the glyph rows
  logic [1:0][2:0]            phase;  // pixel within the current byte
  logic [1:0][rom_addr_w-1:0] addr;   // running byte address

  // ------------------------------------------------------------
  // one slice per glyph, only placement and base differ
  // ------------------------------------------------------------
  for (genvar g = 0; g < 2; g++) begin : gen_glyph
    logic [hcnt_w-1:0]     x_lo;  // leftmost column
    logic [vcnt_w-1:0]     y_lo;  // top row
    logic [rom_addr_w-1:0] base;  // first byte in ROM

    assign x_lo = (g == 0) ? hcnt_w'(glyph0_x) : hcnt_w'(glyph1_x);
    assign y_lo = (g == 0) ? vcnt_w'(glyph0_y) : vcnt_w'(glyph1_y);
    assign base = rom_addr_w'(g * glyph_bytes);

    assign win[g] = (raster.hcnt >= x_lo) &&
                    (raster.hcnt <= x_lo + (glyph_w - 1));
    // same width, shifted left by the ROM latency
    assign pre[g] = (raster.hcnt + rom_lead >= x_lo) &&
                    (raster.hcnt + rom_lead <= x_lo + (glyph_w - 1));
    assign rows[g] = (raster.vcnt >= y_lo) &&
                     (raster.vcnt <= y_lo + (glyph_h - 1));

    always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
        phase[g] <= 3'd0;
        addr[g]  <= base;
      end else if (!raster.vsync) begin
        // new frame, rewind to the glyph's first byte
        phase[g] <= 3'd0;
        addr[g]  <= base;
      end else if (pre[g] && rows[g]) begin
        phase[g] <= phase[g] + 3'd1;  // wraps 7 -> 0
        if (phase[g] == 3'd7)
          addr[g] <= addr[g] + rom_addr_w'(1);  // next 8 pixels
      end else begin
        phase[g] <= 3'd0;  // realign for the next row
      end
    end
  end

  // ------------------------------------------------------------
  // single ROM port and window flag
  // ------------------------------------------------------------
  // glyph 1 only when it is really fetching, else glyph 0 sits on the port
  assign rom_addr = (pre[1] && rows[1]) ? addr[1] : addr[0];
  assign glyph_on = |(win & rows);

  // windows must not overlap or the shared port would be fought over
  a_pre_excl : assert property (@(posedge vga_clk) disable iff (!reset_n)
    !(pre[0] && pre[1]));

endmodule

`default_nettype wire

/* src/glyph_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_rom (
  input  logic                           vga_clk,
  input  logic [vga_pkg::rom_addr_w-1:0] rom_addr,
  output logic [7:0]                     rom_data
);
  import vga_pkg::*;

  logic [7:0]            mem [rom_depth];
  logic [rom_addr_w-1:0] addr_q;  // first pipeline stage

  // one byte of the two synthetic glyphs
  // glyph 0 hollow frame, glyph 1 8x8 checkerboard
  function automatic logic [7:0] glyph_byte(int unsigned a);
    int unsigned off;
    int unsigned row;
    int unsigned col;
    logic        second;
    logic [7:0]  bits;
    second = (a >= glyph_bytes);
    off    = second ? a - glyph_bytes : a;
    row    = off / glyph_bytes_per_row;
    for (int k = 0; k < 8; k++) begin
      col = (off % glyph_bytes_per_row) * 8 + k;  // k = 0 is leftmost
      if (!second)
        bits[7-k] = (row == 0) || (row == glyph_h - 1) ||
                    (col == 0) || (col == glyph_w - 1);
      else
        bits[7-k] = row[3] ^ col[3];
    end
    return bits;
  endfunction

  // contents fixed at start-up, no write port
  initial begin
    for (int i = 0; i < rom_depth; i++)
      mem[i] = glyph_byte(i);
  end

  // ------------------------------------------------------------
  // read pipeline, address then data, two clocks total
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    addr_q   <= rom_addr;
    rom_data <= mem[addr_q];
  end

endmodule

`default_nettype wire

/* src/glyph_pixel.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_pixel (
  input  logic             vga_clk,
  input  logic             reset_n,
  input  vga_pkg::raster_t raster,
  input  logic             glyph_on,
  input  logic [7:0]       rom_data,
  output vga_pkg::rgb565_t rgb
);
  import vga_pkg::*;

  logic [2:0] bit_idx;  // 7 = leftmost pixel of the byte
  logic       active;   // inside the 800x600 area

  assign active = raster.hde & raster.vde;

  // ------------------------------------------------------------
  // bit select walks 7 -> 0 in step with the ROM bytes
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (!reset_n) begin
      bit_idx <= 3'd7;
    end else if (!raster.vsync) begin
      bit_idx <= 3'd7;
    end else if (glyph_on) begin
      bit_idx <= bit_idx - 3'd1;  // 0 wraps back to 7 for the next byte
    end else begin
      bit_idx <= 3'd7;  // ready for the first column
    end
  end

  // ------------------------------------------------------------
  // colour mux
  // ------------------------------------------------------------
  always_comb begin
    rgb.r = glyph_on ? {5{rom_data[bit_idx]}} : 5'd0;  // mono glyph in red
    rgb.g = active ? 6'd3 : 6'd0;                      // dark background
    rgb.b = active ? 5'd3 : 5'd0;
  end

  // glyph windows lie wholly inside the visible area
  a_glyph_visible : assert property (@(posedge vga_clk) disable iff (!reset_n)
    glyph_on |-> active);

endmodule

`default_nettype wire

/* src/vga_char_display.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_char_display (
  input  logic       vga_clk,
  input  logic       reset_n,
  output logic       vga_hs,
  output logic       vga_vs,
  output logic [4:0] vga_r,
  output logic [5:0] vga_g,
  output logic [4:0] vga_b
);
  import vga_pkg::*;

  raster_t               raster;    // counters, syncs, enables
  logic [rom_addr_w-1:0] rom_addr;
  logic [7:0]            rom_data;
  logic                  glyph_on;
  rgb565_t               rgb;

  // ------------------------------------------------------------
  // raster -> fetch -> ROM -> pixel
  // ------------------------------------------------------------
  vga_timing vga_timing_i (
    .vga_clk (vga_clk),
    .reset_n (reset_n),
    .raster  (raster)
  );

  glyph_fetch glyph_fetch_i (
    .vga_clk  (vga_clk),
    .reset_n  (reset_n),
    .raster   (raster),
    .rom_addr (rom_addr),
    .glyph_on (glyph_on)
  );

  glyph_rom glyph_rom_i (
    .vga_clk  (vga_clk),
    .rom_addr (rom_addr),
    .rom_data (rom_data)  // two clocks behind rom_addr
  );

  glyph_pixel glyph_pixel_i (
    .vga_clk  (vga_clk),
    .reset_n  (reset_n),
    .raster   (raster),
    .glyph_on (glyph_on),
    .rom_data (rom_data),
    .rgb      (rgb)
  );

  // pins
  assign vga_hs = raster.hsync;
  assign vga_vs = raster.vsync;
  assign vga_r  = rgb.r;
  assign vga_g  = rgb.g;
  assign vga_b  = rgb.b;

endmodule

`default_nettype wire

/* bench/tb_vga_char_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_char_display;
  import vga_pkg::*;

  localparam int    clk_half     = 4;                   // 8 ns period, 125 MHz sim clock
  localparam int    reset_cycles = 4;
  localparam int    frame_cycles = h_total * v_total;   // 663168
  localparam int    run_cycles   = 2 * frame_cycles;    // two whole frames
  localparam longint watchdog_ns = longint'(frame_cycles) * 2 * clk_half * 22 / 10;

  logic       vga_clk;
  logic       reset_n;
  logic       vga_hs;
  logic       vga_vs;
  logic [4:0] vga_r;
  logic [5:0] vga_g;
  logic [4:0] vga_b;

  // reference raster model
  logic [hcnt_w-1:0] mh;        // model hcnt, 1 .. h_total
  logic [vcnt_w-1:0] mv;        // model vcnt, 1 .. v_total
  logic              model_ok;  // model has seen reset
  logic              rst_q;     // DUT flops hold reset values this cycle

  logic       exp_hs;
  logic       exp_vs;
  logic       exp_hde;
  logic       exp_vde;
  logic       in_g0;
  logic       in_g1;
  logic [4:0] exp_r;
  logic [5:0] exp_g;
  logic [4:0] exp_b;

  vga_char_display vga_char_display_i (
    .vga_clk (vga_clk),
    .reset_n (reset_n),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
  );

  // ------------------------------------------------------------
  // clock, reset, run length
  // ------------------------------------------------------------
  initial vga_clk = 1'b0;
  always #clk_half vga_clk = ~vga_clk;

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge vga_clk);
    @(negedge vga_clk);
    reset_n = 1'b1;                    // released mid-cycle, H = 1 here
    repeat (run_cycles) @(posedge vga_clk);
    @(negedge vga_clk);                // let the last sample settle
    $display("=== PASS ===");
    $finish;
  end

  // hard stop if the run overshoots
  initial begin
    #(watchdog_ns);
    stop_with_failure("watchdog expired, simulation ran past its expected length");
  end

  // ------------------------------------------------------------
  // failure reporting
  // ------------------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s: expected %0h, actual %0h at %0t", test, exp, act, $time);
    stop_with_failure("value mismatch against the raster model");
  endtask

  // ------------------------------------------------------------
  // glyph pixel rule
  // ------------------------------------------------------------
  // hollow frame, border rows and columns lit
  function automatic logic frame_pixel(input int row, input int col);
    return (row == 0) || (row == glyph_h - 1) || (col == 0) || (col == glyph_w - 1);
  endfunction

  // 8x8 checkerboard, lit where row and column blocks disagree
  function automatic logic checker_pixel(input int row, input int col);
    return ((row / 8) % 2) != ((col / 8) % 2);
  endfunction

  // ------------------------------------------------------------
  // model counters, same stepping as the raster spec
  // ------------------------------------------------------------
  initial begin
    model_ok = 1'b0;
    rst_q    = 1'b0;
  end

  always @(posedge vga_clk) begin
    rst_q <= !reset_n;
    if (!reset_n) begin
      mh       <= hcnt_w'(1);
      mv       <= vcnt_w'(1);
      model_ok <= 1'b1;
    end else if (mh == hcnt_w'(h_total)) begin
      mh <= hcnt_w'(1);  // line wrap
      mv <= (mv == vcnt_w'(v_total)) ? vcnt_w'(1) : mv + vcnt_w'(1);
    end else begin
      mh <= mh + hcnt_w'(1);
    end
  end

  // expected pins, all derived from mh / mv
  always_comb begin
    exp_hs  = !((mh >= 2) && (mh <= h_sync_len));
    // vertical flags lag vcnt by one clock, so the edges sit at H = 2
    exp_vs  = !(((mv == 1) && (mh != 1)) || (mv == 2) || (mv == 3) ||
                ((mv == v_sync_len) && (mh == 1)));
    exp_hde = (mh > h_de_start) && (mh <= h_de_end);
    exp_vde = ((mv == v_de_start) && (mh != 1)) ||
              ((mv > v_de_start) && (mv < v_de_end)) ||
              ((mv == v_de_end) && (mh == 1));
    exp_g   = (exp_hde && exp_vde) ? 6'd3 : 6'd0;
    exp_b   = (exp_hde && exp_vde) ? 5'd3 : 5'd0;

    in_g0 = (mh >= glyph0_x) && (mh < glyph0_x + glyph_w) &&
            (mv >= glyph0_y) && (mv < glyph0_y + glyph_h);
    in_g1 = (mh >= glyph1_x) && (mh < glyph1_x + glyph_w) &&
            (mv >= glyph1_y) && (mv < glyph1_y + glyph_h);

    exp_r = 5'd0;
    if (in_g0 && frame_pixel(int'(mv) - glyph0_y, int'(mh) - glyph0_x))
      exp_r = 5'd31;
    if (in_g1 && checker_pixel(int'(mv) - glyph1_y, int'(mh) - glyph1_x))
      exp_r = 5'd31;
  end

  // ------------------------------------------------------------
  // checks, sampled on the rising edge
  // ------------------------------------------------------------
  // reset state, {hs, vs, r, g, b}
  chk_reset_state : assert property (@(posedge vga_clk)
    rst_q |-> ({vga_hs, vga_vs, vga_r, vga_g, vga_b} == {2'b11, 16'd0}))
    else report_mismatch("reset_state", {14'd0, 2'b11, 16'd0},
                         {14'd0, $sampled({vga_hs, vga_vs, vga_r, vga_g, vga_b})});

  chk_hsync : assert property (@(posedge vga_clk) model_ok |-> (vga_hs == exp_hs))
    else report_mismatch("hsync", $sampled(exp_hs), $sampled(vga_hs));

  chk_vsync : assert property (@(posedge vga_clk) model_ok |-> (vga_vs == exp_vs))
    else report_mismatch("vsync", $sampled(exp_vs), $sampled(vga_vs));

  chk_bg_green : assert property (@(posedge vga_clk) model_ok |-> (vga_g == exp_g))
    else report_mismatch("background_g", $sampled(exp_g), $sampled(vga_g));

  chk_bg_blue : assert property (@(posedge vga_clk) model_ok |-> (vga_b == exp_b))
    else report_mismatch("background_b", $sampled(exp_b), $sampled(vga_b));

  // glyph 0, both frames, so the vsync rewind is covered too
  chk_glyph0 : assert property (@(posedge vga_clk)
    (model_ok && in_g0) |-> (vga_r == exp_r))
    else report_mismatch("glyph0", $sampled(exp_r), $sampled(vga_r));

  chk_glyph1 : assert property (@(posedge vga_clk)
    (model_ok && in_g1) |-> (vga_r == exp_r))
    else report_mismatch("glyph1", $sampled(exp_r), $sampled(vga_r));

  // red stays dark everywhere else, porches included
  chk_red_outside : assert property (@(posedge vga_clk)
    (model_ok && !in_g0 && !in_g1) |-> (vga_r == 5'd0))
    else report_mismatch("red_outside", 32'd0, $sampled(vga_r));

endmodule

`default_nettype wire

/* build.f */
src/vga_pkg.sv
src/vga_timing.sv
src/glyph_fetch.sv
src/glyph_rom.sv
src/glyph_pixel.sv
src/vga_char_display.sv
bench/tb_vga_char_display.sv
